/* cam_array.sv */
/* Behavioral CAM with one write port and one compare port
   Match is registered, valid one cycle after cm_valid, held until the next compare
   A write and a compare in the same cycle compare against the old contents */
`timescale 1ns/1ps
`include "cam_bist_macros.svh"

module cam_array (
   input  logic                    bist_clk,
   input  logic                    rst_b,
   input  logic                    wr_en,
   input  cam_bist_pkg::cam_idx_t   wr_idx,
   input  cam_bist_pkg::cam_data_t  wr_data,
   input  logic                    cm_valid,
   input  cam_bist_pkg::cam_data_t  cm_data,
   output cam_bist_pkg::cam_match_t match
);
   import cam_bist_pkg::*;

   // Storage
   cam_data_t  mem [`CAM_ENTRIES];
   // Unregistered hit vector
   cam_match_t hit;

   // --------------------
   // Write port
   // --------------------

   // Every entry starts at zero
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         for (int e = 0; e < `CAM_ENTRIES; e++) begin
            mem[e] <= '0;
         end
      end else if (wr_en) begin
         mem[wr_idx] <= wr_data;
      end
   end

   // --------------------
   // Compare port
   // --------------------

   // Full-word equality per entry
   always_comb begin
      for (int e = 0; e < `CAM_ENTRIES; e++) begin
         hit[e] = (mem[e] == cm_data);
      end
   end

   // Hold the last result between compares
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         match <= '0;
      end else if (cm_valid) begin
         match <= hit;
      end
   end

endmodule

/* cam_bist_checker.sv */
/* Response checker with a one-stage expected-value pipe
   Only the first failing entry is kept, lowest index wins within a vector */
`timescale 1ns/1ps
`include "cam_bist_macros.svh"

module cam_bist_checker (
   input  logic                    bist_clk,
   input  logic                    rst_b,
   input  logic                    bist_start,
   input  logic                    exp_valid,
   input  cam_bist_pkg::cam_match_t exp_match,
   input  cam_bist_pkg::cam_match_t match,
   output logic                    bist_fail,
   output cam_bist_pkg::cam_idx_t   fail_entry
);
   import cam_bist_pkg::*;

   logic       exp_valid_q;
   cam_match_t exp_match_q;
   cam_match_t diff;

   // Lowest set bit of a mismatch vector
   function automatic cam_idx_t low_idx(input cam_match_t v);
      cam_idx_t idx;
      idx = '0;
      for (int i = `CAM_ENTRIES - 1; i >= 0; i--) begin
         if (v[i]) idx = cam_idx_t'(i);
      end
      return idx;
   endfunction

   // Line up expected with the registered match
   always_ff @(posedge bist_clk) begin
      if (!rst_b) exp_valid_q <= 1'b0;
      else        exp_valid_q <= exp_valid;
   end

   always_ff @(posedge bist_clk) begin
      exp_match_q <= exp_match;
   end

   assign diff = exp_match_q ^ match;

   // Sticky until the next accepted start
   always_ff @(posedge bist_clk) begin
      if (!rst_b || bist_start) begin
         bist_fail  <= 1'b0;
         fail_entry <= '0;
      end else if (exp_valid_q && (diff != '0) && !bist_fail) begin
         bist_fail  <= 1'b1;
         fail_entry <= low_idx(diff);
      end
   end

endmodule

/* cam_bist_if.sv */
/* Test controls from the sequencer to the input handler
   All signals are plain levels or one-cycle strobes, no handshake */
`timescale 1ns/1ps

interface cam_bist_if;
   import cam_bist_pkg::*;

   // BIST owns the compare data
   logic      cm_mode;
   // Rotate the flip mask left by one at the next edge
   logic      rotate_mask;
   // XOR the flip mask into the compare data
   logic      cd_mask_enable;
   // Invert data for the current pass
   logic      data_inv;
   // Background pattern
   cam_data_t wr_data;
   // Pattern after optional inversion
   cam_data_t wr_data_out;

   // Sequencer side
   modport seq (
      output cm_mode,
      output rotate_mask,
      output cd_mask_enable,
      output data_inv,
      output wr_data,
      input  wr_data_out
   );

   // Input handler side
   modport inh (
      input  cm_mode,
      input  rotate_mask,
      input  cd_mask_enable,
      input  data_inv,
      input  wr_data,
      output wr_data_out
   );

endinterface

/* cam_bist_inhandler.sv */
/* Data path into the CAM during test
   Purely combinational except the flip mask, which only moves on rotate_mask */
`timescale 1ns/1ps
`include "cam_bist_macros.svh"

module cam_bist_inhandler (
   input  logic                  bist_clk,
   input  logic                  rst_b,
   cam_bist_if.inh               bus,
   input  cam_bist_pkg::cam_data_t func_cm_data,
   output cam_bist_pkg::cam_data_t cm_data
);
   import cam_bist_pkg::*;

   // One-hot flip mask
   cam_data_t bist_mask;
   // Mask after the enable gate
   cam_data_t gated_mask;
   // BIST compare word
   cam_data_t bist_cm_data;

   // --------------------
   // Rotating mask
   // --------------------

   // Starts at bit 0, the top bit wraps back to bit 0
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         bist_mask <= cam_data_t'(1);
      end else if (bus.rotate_mask) begin
         bist_mask <= {bist_mask[`CAM_DWIDTH-2:0], bist_mask[`CAM_DWIDTH-1]};
      end
   end

   // --------------------
   // Data generation
   // --------------------

   // Write data, pattern or its complement
   assign bus.wr_data_out = bus.wr_data ^ {`CAM_DWIDTH{bus.data_inv}};

   // Flip a single bit only while masked compares run
   assign gated_mask = bist_mask & {`CAM_DWIDTH{bus.cd_mask_enable}};

   assign bist_cm_data = bus.wr_data_out ^ gated_mask;

   // Functional compare data passes straight through outside of test
   assign cm_data = bus.cm_mode ? bist_cm_data : func_cm_data;

endmodule

/* cam_bist_macros.svh */
/* Geometry of the CAM under test
   CAM_IDX_W must equal clog2(CAM_ENTRIES), and CAM_DWIDTH must be at least CAM_ENTRIES */
`ifndef CAM_BIST_MACROS_SVH
`define CAM_BIST_MACROS_SVH

// --------------------
// Array geometry
// --------------------

// Bits per CAM word, also the number of rotating mask compares per pass
`define CAM_DWIDTH 16

// Number of CAM entries
`define CAM_ENTRIES 8

// Entry index width
`define CAM_IDX_W 3

`endif

/* cam_bist_pkg.sv */
/* Shared types for the CAM self-test
   Widths come from the macros header */
`include "cam_bist_macros.svh"

package cam_bist_pkg;

   // --------------------
   // Vector types
   // --------------------

   // One CAM word, also used for compare data and the flip mask
   typedef logic [`CAM_DWIDTH-1:0] cam_data_t;

   // One hit bit per entry
   typedef logic [`CAM_ENTRIES-1:0] cam_match_t;

   // Entry index
   typedef logic [`CAM_IDX_W-1:0] cam_idx_t;

   // --------------------
   // Sequencer states
   // --------------------

   typedef enum logic [2:0] {
      IDLE,       // Waiting for a start pulse
      WRITE,      // Background write, one entry per cycle
      CMP_ALL,    // Unmasked compare, every entry must hit
      CMP_ROT,    // One-hot masked compares, no entry may hit
      NEXT_PASS,  // Switch to inverted data or finish
      DONE        // Drain the last match before raising done
   } bist_state_t;

endpackage

/* cam_bist_seq.sv */
/* Two-pass CAM test sequencer, the second pass uses inverted data
   A run lasts 2*(CAM_ENTRIES+1+CAM_DWIDTH+1)+2 cycles from start to done
   A start pulse is only taken in IDLE */
`timescale 1ns/1ps
`include "cam_bist_macros.svh"

module cam_bist_seq (
   input  logic                    bist_clk,
   input  logic                    rst_b,
   input  logic                    bist_start,
   input  cam_bist_pkg::cam_data_t  bist_pattern,
   cam_bist_if.seq                 bus,
   output logic                    bist_wr_en,
   output cam_bist_pkg::cam_idx_t   bist_wr_idx,
   output logic                    bist_cm_valid,
   output logic                    exp_valid,
   output cam_bist_pkg::cam_match_t exp_match,
   output logic                    bist_busy,
   output logic                    bist_done
);
   import cam_bist_pkg::*;

   // Counter covers entries, mask bits and the drain wait
   localparam int CNT_W = $clog2(`CAM_DWIDTH);
   localparam logic [CNT_W-1:0] LAST_ENTRY = CNT_W'(`CAM_ENTRIES - 1);
   localparam logic [CNT_W-1:0] LAST_BIT   = CNT_W'(`CAM_DWIDTH - 1);
   localparam logic [CNT_W-1:0] LAST_WAIT  = CNT_W'(1);

   bist_state_t      state;
   logic [CNT_W-1:0] cnt;
   logic             second_pass;
   logic             done_q;
   // Background pattern held for the whole run
   cam_data_t        pattern_q;

   // --------------------
   // State machine
   // --------------------

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         state       <= IDLE;
         cnt         <= '0;
         second_pass <= 1'b0;
         done_q      <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (bist_start) begin
                  state       <= WRITE;
                  cnt         <= '0;
                  second_pass <= 1'b0;
                  done_q      <= 1'b0;
               end
            end
            WRITE: begin
               if (cnt == LAST_ENTRY) begin
                  cnt   <= '0;
                  state <= CMP_ALL;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            // Single cycle, counter already back at zero
            CMP_ALL: state <= CMP_ROT;
            CMP_ROT: begin
               if (cnt == LAST_BIT) begin
                  cnt   <= '0;
                  state <= NEXT_PASS;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            NEXT_PASS: begin
               if (second_pass) begin
                  state <= DONE;
               end else begin
                  second_pass <= 1'b1;
                  state       <= WRITE;
               end
            end
            // Two cycles so the last match reaches the checker
            DONE: begin
               if (cnt == LAST_WAIT) begin
                  cnt    <= '0;
                  done_q <= 1'b1;
                  state  <= IDLE;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge bist_clk) begin
      if (state == IDLE && bist_start) begin
         pattern_q <= bist_pattern;
      end
   end

   // --------------------
   // Outputs
   // --------------------

   assign bist_busy = (state != IDLE);
   assign bist_done = done_q;

   assign bist_wr_en  = (state == WRITE);
   assign bist_wr_idx = cnt[`CAM_IDX_W-1:0];

   // Every compare carries an expected vector in the same cycle
   assign bist_cm_valid = (state == CMP_ALL) || (state == CMP_ROT);
   assign exp_valid     = bist_cm_valid;
   assign exp_match     = {`CAM_ENTRIES{state == CMP_ALL}};

   // Handler controls
   assign bus.cm_mode        = bist_busy;
   assign bus.rotate_mask    = (state == CMP_ROT);
   assign bus.cd_mask_enable = (state == CMP_ROT);
   assign bus.data_inv       = second_pass;
   assign bus.wr_data        = pattern_q;

endmodule

/* cam_bist_sva.sv */
/* Assertions bound into the CAM BIST top level
   No fault is ever injected, so any raised fail flag is an error */
`timescale 1ns/1ps

module cam_bist_sva (
   input logic                      bist_clk,
   input logic                      rst_b,
   input logic                      bist_busy,
   input logic                      bist_done,
   input logic                      bist_fail,
   input logic                      rotate_mask,
   input cam_bist_pkg::bist_state_t state,
   input cam_bist_pkg::cam_data_t   mask
);
   import cam_bist_pkg::*;

   // Done is only raised once the sequencer is idle
   done_not_busy: assert property (@(posedge bist_clk) disable iff (!rst_b)
      !(bist_done && bist_busy))
      else $error("bist_done and bist_busy high together");

   clean_run: assert property (@(posedge bist_clk) disable iff (!rst_b)
      !bist_fail)
      else $error("bist_fail raised on a fault-free array");

   // --------------------
   // Mask register
   // --------------------

   mask_onehot: assert property (@(posedge bist_clk) disable iff (!rst_b)
      $onehot(mask))
      else $error("flip mask is not one-hot");

   // Mask only moves after a rotate strobe issued in CMP_ROT
   rotate_in_cmp_rot: assert property (@(posedge bist_clk) disable iff (!rst_b)
      (mask != $past(mask)) |-> ($past(rotate_mask) && ($past(state) == CMP_ROT)))
      else $error("flip mask moved without a rotate strobe from CMP_ROT");

   // Full rotation per pass brings the mask home
   mask_home_idle: assert property (@(posedge bist_clk) disable iff (!rst_b)
      (state == IDLE) |-> (mask == cam_data_t'(1)))
      else $error("flip mask not at bit 0 while idle");

endmodule

bind cam_bist_top cam_bist_sva i_sva (
   .bist_clk    (bist_clk),
   .rst_b       (rst_b),
   .bist_busy   (bist_busy),
   .bist_done   (bist_done),
   .bist_fail   (bist_fail),
   .rotate_mask (bist_bus.rotate_mask),
   .state       (i_seq.state),
   .mask        (i_inh.bist_mask)
);

/* cam_bist_top.sv */
/* CAM with built-in self-test
   Functional writes, compares and starts are ignored while bist_busy is high
   func_match is the shared match register and also changes during a run */
`timescale 1ns/1ps

module cam_bist_top (
   input  logic                    bist_clk,
   input  logic                    rst_b,
   input  logic                    bist_start,
   input  cam_bist_pkg::cam_data_t  bist_pattern,
   input  logic                    func_wr_en,
   input  cam_bist_pkg::cam_idx_t   func_wr_idx,
   input  cam_bist_pkg::cam_data_t  func_wr_data,
   input  logic                    func_cm_valid,
   input  cam_bist_pkg::cam_data_t  func_cm_data,
   output cam_bist_pkg::cam_match_t func_match,
   output logic                    bist_busy,
   output logic                    bist_done,
   output logic                    bist_fail,
   output cam_bist_pkg::cam_idx_t   fail_entry
);
   import cam_bist_pkg::*;

   cam_bist_if bist_bus ();

   logic       bist_wr_en;
   cam_idx_t   bist_wr_idx;
   logic       bist_cm_valid;
   logic       exp_valid;
   cam_match_t exp_match;
   // Start as seen by the sequencer, so a late pulse cannot clear the checker
   logic       start_acc;

   // Array side after the mux
   logic       wr_en;
   cam_idx_t   wr_idx;
   cam_data_t  wr_data;
   logic       cm_valid;
   cam_data_t  cm_data;
   cam_match_t match;

   assign start_acc = bist_start && !bist_busy;

   cam_bist_seq i_seq (
      .bist_clk, .rst_b, .bist_start, .bist_pattern, .bus(bist_bus.seq),
      .bist_wr_en, .bist_wr_idx, .bist_cm_valid, .exp_valid, .exp_match,
      .bist_busy, .bist_done
   );

   // Compare data mux lives in the handler
   cam_bist_inhandler i_inh (
      .bist_clk, .rst_b, .bus(bist_bus.inh), .func_cm_data, .cm_data
   );

   // --------------------
   // Access mux
   // --------------------

   assign wr_en    = bist_busy ? bist_wr_en : func_wr_en;
   assign wr_idx   = bist_busy ? bist_wr_idx : func_wr_idx;
   assign wr_data  = bist_busy ? bist_bus.wr_data_out : func_wr_data;
   assign cm_valid = bist_busy ? bist_cm_valid : func_cm_valid;

   cam_array i_array (
      .bist_clk, .rst_b, .wr_en, .wr_idx, .wr_data, .cm_valid, .cm_data, .match
   );

   cam_bist_checker i_checker (
      .bist_clk, .rst_b, .bist_start(start_acc), .exp_valid, .exp_match, .match,
      .bist_fail, .fail_entry
   );

   assign func_match = match;

endmodule

/* files.f */
+incdir+.
cam_bist_pkg.sv
cam_bist_if.sv
cam_bist_inhandler.sv
cam_array.sv
cam_bist_seq.sv
cam_bist_checker.sv
cam_bist_top.sv
cam_bist_sva.sv
tb_cam_bist.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CAM BIST testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f files.f --top-module tb_cam_bist -o tb_cam_bist
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_cam_bist > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Verification failed" "$LOG"; then
   exit 1
fi
exit 0

/* tb_cam_bist.sv */
/* Testbench for the CAM with built-in self-test
   Checks functional traffic against a shadow model and the BIST run length, done and fail
   Every BIST run is expected to be clean, there is no fault injection */
`timescale 1ns/1ps
`include "cam_bist_macros.svh"

module tb_cam_bist;
   import cam_bist_pkg::*;

   // --------------------
   // Test sizes
   // --------------------

   // Start sample to done, two passes plus the drain
   localparam int RUN_CYCLES = 2 * (`CAM_ENTRIES + 1 + `CAM_DWIDTH + 1) + 2;
   localparam int NUM_WR     = 12;
   localparam int NUM_CMP    = 16;
   localparam int NUM_RUNS   = 5;
   // Reset compare, random traffic, two compares per run, two disturb windows
   localparam int NUM_OPS    = 1 + NUM_WR + NUM_CMP + 2 * NUM_RUNS + 2;
   localparam int WATCHDOG_CYCLES = 10 + 200 * NUM_RUNS + 4 * NUM_OPS;

   logic       bist_clk = 1'b0;
   logic       rst_b;
   logic       bist_start;
   cam_data_t  bist_pattern;
   logic       func_wr_en;
   cam_idx_t   func_wr_idx;
   cam_data_t  func_wr_data;
   logic       func_cm_valid;
   cam_data_t  func_cm_data;
   cam_match_t func_match;
   logic       bist_busy;
   logic       bist_done;
   logic       bist_fail;
   cam_idx_t   fail_entry;

   // Counters of the main sequence and of the compare process
   int          errors;
   int          checks;
   int          cmp_errors = 0;
   int          cmp_checks = 0;
   logic [31:0] lfsr;

   // Shadow CAM and the pending functional compare
   cam_data_t  shadow [`CAM_ENTRIES];
   cam_match_t exp_q;
   logic       pend_q;

   cam_bist_top i_cam_bist_top (
      .bist_clk      (bist_clk),
      .rst_b         (rst_b),
      .bist_start    (bist_start),
      .bist_pattern  (bist_pattern),
      .func_wr_en    (func_wr_en),
      .func_wr_idx   (func_wr_idx),
      .func_wr_data  (func_wr_data),
      .func_cm_valid (func_cm_valid),
      .func_cm_data  (func_cm_data),
      .func_match    (func_match),
      .bist_busy     (bist_busy),
      .bist_done     (bist_done),
      .bist_fail     (bist_fail),
      .fail_entry    (fail_entry)
   );

   // 8 ns period
   always #4 bist_clk = ~bist_clk;

   // --------------------
   // Helpers
   // --------------------

   // Galois LFSR, taps 32 31 29 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Expected hit vector from the shadow CAM
   function automatic cam_match_t ref_match(input cam_data_t data);
      cam_match_t m;
      for (int e = 0; e < `CAM_ENTRIES; e++) begin
         m[e] = (shadow[e] === data);
      end
      return m;
   endfunction

   task automatic print_fail(input string msg);
      $display("[FAIL] %0t ns: %s", $time, msg);
   endtask

   task automatic func_write(input cam_idx_t idx, input cam_data_t data);
      @(posedge bist_clk);
      #1;
      func_wr_en   = 1'b1;
      func_wr_idx  = idx;
      func_wr_data = data;
      @(posedge bist_clk);
      #1;
      func_wr_en = 1'b0;
   endtask

   task automatic func_compare(input cam_data_t data);
      @(posedge bist_clk);
      #1;
      func_cm_valid = 1'b1;
      func_cm_data  = data;
      @(posedge bist_clk);
      #1;
      func_cm_valid = 1'b0;
   endtask

   // Compare and check against a fixed expected vector
   task automatic compare_expect(input cam_data_t data, input cam_match_t exp,
                                 input string what);
      func_compare(data);
      @(negedge bist_clk);
      checks++;
      if (func_match !== exp) begin
         errors++;
         print_fail($sformatf("%s: func_match %h, expected %h", what, func_match, exp));
      end
   endtask

   // Writes, compares and a second start that the busy DUT must ignore
   task automatic drive_during_run(input int cycle, input cam_data_t pat);
      if (cycle == 3 || cycle == 30) begin
         bist_start    = 1'b1;
         bist_pattern  = ~pat;
         func_wr_en    = 1'b1;
         func_wr_idx   = cam_idx_t'(rand_bits(`CAM_IDX_W));
         func_wr_data  = cam_data_t'(rand_bits(`CAM_DWIDTH));
         func_cm_valid = 1'b1;
         func_cm_data  = pat;
      end else begin
         bist_start    = 1'b0;
         func_wr_en    = 1'b0;
         func_cm_valid = 1'b0;
      end
   endtask

   // Full run, timing, status and contents afterwards
   task automatic run_bist(input cam_data_t pat, input logic disturb);
      int cycles;
      cycles = 0;
      @(posedge bist_clk);
      #1;
      bist_pattern = pat;
      bist_start   = 1'b1;
      @(posedge bist_clk);
      #1;
      bist_start = 1'b0;
      checks++;
      if (bist_busy !== 1'b1 || bist_done !== 1'b0) begin
         errors++;
         print_fail($sformatf("busy %b done %b after start", bist_busy, bist_done));
      end
      // Cycle count is taken at each falling edge
      while (bist_done !== 1'b1 && cycles < 2 * RUN_CYCLES) begin
         @(posedge bist_clk);
         #1;
         if (disturb) drive_during_run(cycles, pat);
         @(negedge bist_clk);
         cycles++;
      end
      checks++;
      if (bist_done !== 1'b1) begin
         errors++;
         $display("BIST run with pattern %h never raised bist_done", pat);
      end else if (cycles != RUN_CYCLES) begin
         errors++;
         print_fail($sformatf("bist_done after %0d cycles, expected %0d", cycles, RUN_CYCLES));
      end
      checks++;
      if (bist_fail !== 1'b0 || fail_entry !== '0 || bist_busy !== 1'b0) begin
         errors++;
         print_fail($sformatf("pattern %h: fail %b entry %0d busy %b at done",
                              pat, bist_fail, fail_entry, bist_busy));
      end
      // Second pass leaves the complement in every entry
      compare_expect(~pat, '1, "inverted pattern after run");
      compare_expect(pat, '0, "pattern after run");
      checks++;
      if (bist_done !== 1'b1) begin
         errors++;
         print_fail("bist_done dropped before the next start");
      end
   endtask

   // --------------------
   // Compare process
   // --------------------

   // Expected value taken before the write of the same cycle
   always @(negedge bist_clk) begin
      if (!rst_b) begin
         pend_q <= 1'b0;
         exp_q  <= '0;
         for (int e = 0; e < `CAM_ENTRIES; e++) begin
            shadow[e] <= '0;
         end
      end else begin
         if (pend_q) begin
            cmp_checks++;
            if (func_match !== exp_q) begin
               cmp_errors++;
               print_fail($sformatf("func_match %h, model expects %h", func_match, exp_q));
            end
         end
         pend_q <= func_cm_valid && !bist_busy;
         if (func_cm_valid && !bist_busy) begin
            exp_q <= ref_match(func_cm_data);
         end
         // A clean run ends with the inverted pattern everywhere
         if (bist_start && !bist_busy) begin
            for (int e = 0; e < `CAM_ENTRIES; e++) begin
               shadow[e] <= ~bist_pattern;
            end
         end else if (func_wr_en && !bist_busy) begin
            shadow[func_wr_idx] <= func_wr_data;
         end
      end
   end

   // --------------------
   // Main sequence
   // --------------------

   initial begin
      cam_data_t pat;
      cam_data_t word;
      cam_idx_t  idx;
      cam_data_t written_q[$];
      errors        = 0;
      checks        = 0;
      lfsr          = 32'h550f_c30a;
      rst_b         = 1'b0;
      bist_start    = 1'b0;
      bist_pattern  = '0;
      func_wr_en    = 1'b0;
      func_wr_idx   = '0;
      func_wr_data  = '0;
      func_cm_valid = 1'b0;
      func_cm_data  = '0;
      repeat (10) @(posedge bist_clk);
      #1;
      rst_b = 1'b1;

      // Reset state, all entries cleared
      @(negedge bist_clk);
      checks++;
      if (bist_busy !== 1'b0 || bist_done !== 1'b0 || bist_fail !== 1'b0 ||
          fail_entry !== '0) begin
         errors++;
         print_fail("status outputs not cleared by reset");
      end
      compare_expect('0, '1, "zero after reset");

      // Random functional traffic
      for (int i = 0; i < NUM_WR; i++) begin
         idx  = cam_idx_t'(rand_bits(`CAM_IDX_W));
         word = cam_data_t'(rand_bits(`CAM_DWIDTH));
         written_q.push_back(word);
         func_write(idx, word);
      end
      for (int i = 0; i < NUM_CMP; i++) begin
         if (rand_bits(1) != 0) begin
            word = written_q[rand_bits(4) % written_q.size()];
         end else begin
            word = cam_data_t'(rand_bits(`CAM_DWIDTH));
         end
         func_compare(word);
      end

      // BIST with a random pattern, then the corner patterns
      pat = cam_data_t'(rand_bits(`CAM_DWIDTH));
      run_bist(pat, 1'b0);
      run_bist('0, 1'b0);
      run_bist('1, 1'b0);
      run_bist({(`CAM_DWIDTH / 2){2'b10}}, 1'b0);

      // Disturbed run
      pat = cam_data_t'(rand_bits(`CAM_DWIDTH));
      run_bist(pat, 1'b1);

      repeat (2) @(negedge bist_clk);
      $display("Checks: %0d, errors: %0d", checks + cmp_checks, errors + cmp_errors);
      if (errors + cmp_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge bist_clk);
      $display("Watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
      $display("Verification failed");
      $finish;
   end

endmodule
